// File: tenyr_pkg.sv
`default_nettype none

package tenyr_pkg;

    // instruction field widths
    localparam int OPC_W    = 4;
    localparam int REG_W    = 4;
    localparam int IMM_W    = 16;
    localparam int WORD_W   = 32;
    localparam int NUM_REGS = 16;

    // instruction memory
    localparam int IMEM_DEPTH = 256;
    localparam int IMEM_AW    = 8;

    // credit depths, both powers of two so the queue pointers wrap on their own
    localparam int INSN_CREDITS  = 2;
    localparam int INSN_CNT_W    = $clog2(INSN_CREDITS + 1);
    localparam int INSN_PTR_W    = $clog2(INSN_CREDITS);
    localparam int STORE_CREDITS = 4;
    localparam int STORE_CNT_W   = $clog2(STORE_CREDITS + 1);
    localparam int STORE_PTR_W   = $clog2(STORE_CREDITS);

    // memory map, store addresses come straight from imm
    localparam logic [IMM_W-1:0] DISPLAY_ADDR = 16'h0100;
    localparam logic [IMM_W-1:0] IO_ADDR      = 16'h0200;

    // display scan
    localparam int DISP_W      = 16;
    localparam int DIGIT_W     = 2;
    localparam int SCAN_CYCLES = 4;
    localparam int SCAN_W      = $clog2(SCAN_CYCLES);

    // active low segments, bit 7 is the dot and stays dark
    localparam logic [7:0] SEG_TABLE [16] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0,
        8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83,
        8'hc6, 8'ha1, 8'h86, 8'h8e
    };

    typedef enum logic [OPC_W-1:0] {
        op_add  = 4'h0,
        op_sub  = 4'h1,
        op_and  = 4'h2,
        op_or   = 4'h3,
        op_xor  = 4'h4,
        // rd = zero-extended imm
        op_li   = 4'h5,
        // mem[imm] = ra
        op_st   = 4'h6,
        op_halt = 4'h7,
        op_nop  = 4'h8
    } opcode_t;

    typedef struct packed {
        opcode_t            opcode;
        logic [REG_W-1:0]   rd;
        logic [REG_W-1:0]   ra;
        logic [REG_W-1:0]   rb;
        logic [IMM_W-1:0]   imm;
    } insn_t;

    typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

// File: insn_if.sv
`timescale 1ns/1ps
`default_nettype none

// fetch to execute channel
// credit runs the other way, one pulse per freed queue slot
interface insn_if import tenyr_pkg::*; ();

    logic               valid;
    insn_t              insn;
    logic [IMEM_AW-1:0] pc;
    logic               credit;

    modport src (
        output valid,
        output insn,
        output pc,
        input  credit
    );

    modport dst (
        input  valid,
        input  insn,
        input  pc,
        output credit
    );

endinterface

`default_nettype wire

// File: store_if.sv
`timescale 1ns/1ps
`default_nettype none

// execute to store channel for st traffic
// sender holds a credit for every valid, so there is no ready
interface store_if import tenyr_pkg::*; ();

    logic             valid;
    logic [IMM_W-1:0] addr;
    word_t            data;
    logic             credit;

    modport src (
        output valid,
        output addr,
        output data,
        input  credit
    );

    modport dst (
        input  valid,
        input  addr,
        input  data,
        output credit
    );

endinterface

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import tenyr_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               load_en,
    input  wire logic [IMEM_AW-1:0] load_addr,
    input  wire insn_t              load_data,
    insn_if.src                     out
);

    insn_t                 imem [IMEM_DEPTH];
    logic [IMEM_AW-1:0]    pc;
    logic [INSN_CNT_W-1:0] credit_cnt;
    logic                  halt_sent;
    logic                  halt_out;
    logic                  issue;

    // program load, allowed at any time, reset leaves the contents alone
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    // a halt on the output blocks the issue in the same cycle
    // so nothing after it is ever read
    assign halt_out = out.valid && (out.insn.opcode == op_halt);
    assign issue    = (credit_cnt != '0) && !halt_sent && !halt_out;

    // synchronous read, word shows up on out one cycle after issue
    always_ff @(posedge clk) begin
        if (issue) begin
            out.insn <= imem[pc];
            out.pc   <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc         <= '0;
            credit_cnt <= INSN_CNT_W'(INSN_CREDITS);
            halt_sent  <= 1'b0;
            out.valid  <= 1'b0;
        end else begin
            out.valid <= issue;
            if (issue) begin
                pc <= pc + 1'b1;
            end
            if (halt_out) begin
                halt_sent <= 1'b1;
            end
            // credit returned while issuing cancels out
            if (issue && !out.credit) begin
                credit_cnt <= credit_cnt - 1'b1;
            end else if (!issue && out.credit) begin
                credit_cnt <= credit_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage import tenyr_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    insn_if.dst       in,
    store_if.src      st,
    output logic      halt_seen
);

    insn_t                  q_insn [INSN_CREDITS];
    logic [INSN_PTR_W-1:0]  wr_ptr;
    logic [INSN_PTR_W-1:0]  rd_ptr;
    logic [INSN_CNT_W-1:0]  q_cnt;
    logic [STORE_CNT_W-1:0] st_credit_cnt;
    word_t                  regs [NUM_REGS];
    insn_t                  head;
    word_t                  ra_val;
    word_t                  rb_val;
    word_t                  alu_res;
    logic                   alu_wr;
    logic                   is_st;
    logic                   send_st;
    logic                   retire;

    // input queue payload
    always_ff @(posedge clk) begin
        if (in.valid) begin
            q_insn[wr_ptr] <= in.insn;
        end
    end

    assign head = q_insn[rd_ptr];

    // decode and alu on the queue head
    always_comb begin
        ra_val  = (head.ra == '0) ? '0 : regs[head.ra];
        rb_val  = (head.rb == '0) ? '0 : regs[head.rb];
        alu_res = '0;
        alu_wr  = 1'b0;
        is_st   = 1'b0;
        case (head.opcode)
            op_add: begin
                alu_res = ra_val + rb_val;
                alu_wr  = 1'b1;
            end
            op_sub: begin
                alu_res = ra_val - rb_val;
                alu_wr  = 1'b1;
            end
            op_and: begin
                alu_res = ra_val & rb_val;
                alu_wr  = 1'b1;
            end
            op_or: begin
                alu_res = ra_val | rb_val;
                alu_wr  = 1'b1;
            end
            op_xor: begin
                alu_res = ra_val ^ rb_val;
                alu_wr  = 1'b1;
            end
            op_li: begin
                alu_res = {{(WORD_W - IMM_W){1'b0}}, head.imm};
                alu_wr  = 1'b1;
            end
            op_st: begin
                is_st = 1'b1;
            end
            // halt, nop and unused codes write nothing
            default: begin
                alu_wr = 1'b0;
            end
        endcase
    end

    // st without a store credit waits at the head
    assign retire    = (q_cnt != '0) && !halt_seen && !(is_st && st_credit_cnt == '0);
    assign send_st   = retire && is_st;
    assign in.credit = retire;

    // register file, r0 is never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (retire && alu_wr && head.rd != '0) begin
            regs[head.rd] <= alu_res;
        end
    end

    // store request payload
    always_ff @(posedge clk) begin
        if (send_st) begin
            st.addr <= head.imm;
            st.data <= ra_val;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            q_cnt         <= '0;
            st_credit_cnt <= STORE_CNT_W'(STORE_CREDITS);
            st.valid      <= 1'b0;
            halt_seen     <= 1'b0;
        end else begin
            if (in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (in.valid && !retire) begin
                q_cnt <= q_cnt + 1'b1;
            end else if (!in.valid && retire) begin
                q_cnt <= q_cnt - 1'b1;
            end
            st.valid <= send_st;
            if (send_st && !st.credit) begin
                st_credit_cnt <= st_credit_cnt - 1'b1;
            end else if (!send_st && st.credit) begin
                st_credit_cnt <= st_credit_cnt + 1'b1;
            end
            // halt freezes the queue head for good
            if (retire && head.opcode == op_halt) begin
                halt_seen <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: store_stage.sv
`timescale 1ns/1ps
`default_nettype none

module store_stage import tenyr_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    store_if.dst             in,
    input  wire logic        halt_seen,
    output logic             io_valid,
    output word_t            io_data,
    input  wire logic        io_ready,
    output logic [DISP_W-1:0] display,
    output logic             halt
);

    logic [IMM_W-1:0]       q_addr [STORE_CREDITS];
    word_t                  q_data [STORE_CREDITS];
    logic [STORE_PTR_W-1:0] wr_ptr;
    logic [STORE_PTR_W-1:0] rd_ptr;
    logic [STORE_CNT_W-1:0] q_cnt;
    logic                   not_empty;
    logic                   is_disp;
    logic                   is_io;
    logic                   io_free;
    logic                   pop;

    always_ff @(posedge clk) begin
        if (in.valid) begin
            q_addr[wr_ptr] <= in.addr;
            q_data[wr_ptr] <= in.data;
        end
    end

    // head address decode
    assign not_empty = (q_cnt != '0);
    assign is_disp   = (q_addr[rd_ptr] == DISPLAY_ADDR);
    assign is_io     = (q_addr[rd_ptr] == IO_ADDR);
    // output slot is free when empty or being taken this cycle
    assign io_free   = !io_valid || io_ready;
    // display and unmapped stores leave at once, io waits for the slot
    assign pop       = not_empty && (!is_io || io_free);
    assign in.credit = pop;

    always_ff @(posedge clk) begin
        if (pop && is_io) begin
            io_data <= q_data[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            q_cnt    <= '0;
            io_valid <= 1'b0;
            display  <= '0;
            halt     <= 1'b0;
        end else begin
            if (in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (in.valid && !pop) begin
                q_cnt <= q_cnt + 1'b1;
            end else if (!in.valid && pop) begin
                q_cnt <= q_cnt - 1'b1;
            end
            if (pop && is_disp) begin
                display <= q_data[rd_ptr][DISP_W-1:0];
            end
            // back to back io words keep io_valid high
            if (pop && is_io) begin
                io_valid <= 1'b1;
            end else if (io_ready) begin
                io_valid <= 1'b0;
            end
            // sticky until reset
            if (halt_seen && !not_empty && !io_valid) begin
                halt <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: seg7_scan.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_scan import tenyr_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic [DISP_W-1:0] value,
    output logic [7:0]             seg,
    output logic [3:0]             an
);

    logic [SCAN_W-1:0]  dwell;
    logic [DIGIT_W-1:0] digit;
    logic [3:0]         nibble;

    // digit 0 is the low nibble
    assign nibble = value[{digit, 2'b00} +: 4];

    // seg and an are registered together, so each anode holds
    // SCAN_CYCLES clocks once the scan starts
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dwell <= '0;
            digit <= '0;
            seg   <= 8'hff;
            an    <= 4'hf;
        end else begin
            an  <= ~(4'b0001 << digit);
            seg <= SEG_TABLE[nibble];
            if (dwell == SCAN_W'(SCAN_CYCLES - 1)) begin
                dwell <= '0;
                // wraps 3 -> 0
                digit <= digit + 1'b1;
            end else begin
                dwell <= dwell + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tenyr_top.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_top import tenyr_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               load_en,
    input  wire logic [IMEM_AW-1:0] load_addr,
    input  wire insn_t              load_data,
    output logic                    io_valid,
    output word_t                   io_data,
    input  wire logic               io_ready,
    output logic [7:0]              seg,
    output logic [3:0]              an,
    output logic                    halt
);

    logic [DISP_W-1:0] display;
    logic              halt_seen;

    insn_if  insn_bus ();
    store_if st_bus ();

    // fetch from instruction ram
    fetch_stage fetch0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out       (insn_bus.src)
    );

    execute_stage exec0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (insn_bus.dst),
        .st        (st_bus.src),
        .halt_seen (halt_seen)
    );

    // memory mapped display and output port
    store_stage store0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in        (st_bus.dst),
        .halt_seen (halt_seen),
        .io_valid  (io_valid),
        .io_data   (io_data),
        .io_ready  (io_ready),
        .display   (display),
        .halt      (halt)
    );

    seg7_scan scan0 (
        .clk   (clk),
        .rst_n (rst_n),
        .value (display),
        .seg   (seg),
        .an    (an)
    );

endmodule

`default_nettype wire

// File: tb_tenyr_properties.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tenyr_properties import tenyr_pkg::*; (
    input wire logic                   clk,
    input wire logic                   rst_n,
    input wire logic                   io_valid,
    input wire word_t                  io_data,
    input wire logic                   io_ready,
    input wire logic [3:0]             an,
    input wire logic                   halt,
    input wire logic [INSN_CNT_W-1:0]  fetch_credits,
    input wire logic [STORE_CNT_W-1:0] store_credits
);

    // a word offered and not taken stays put
    io_hold: assert property (@(posedge clk) disable iff (!rst_n)
        io_valid && !io_ready |=> io_valid && $stable(io_data))
        else $error("io_data changed while waiting for io_ready");

    // all ones only in the first cycle out of reset
    an_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(~an) || (an == 4'hf && $past(!rst_n)))
        else $error("anode is not one-hot active low");

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halt |=> halt)
        else $error("halt fell without reset");

    // counters are unsigned, an underflow wraps above the depth
    fetch_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_credits <= INSN_CNT_W'(INSN_CREDITS))
        else $error("fetch credit counter out of range");

    store_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        store_credits <= STORE_CNT_W'(STORE_CREDITS))
        else $error("store credit counter out of range");

endmodule

bind tenyr_top tb_tenyr_properties props0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .io_valid      (io_valid),
    .io_data       (io_data),
    .io_ready      (io_ready),
    .an            (an),
    .halt          (halt),
    .fetch_credits (fetch0.credit_cnt),
    .store_credits (exec0.st_credit_cnt)
);

`default_nettype wire

// File: tb_tenyr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tenyr import tenyr_pkg::*; ();

    localparam int NUM_ENTRIES  = 8;
    localparam int MAX_INSNS    = 12;
    localparam int MAX_WORDS    = 8;
    localparam int RESET_CYCLES = 16;
    // per entry: reset, load, and room for a run under back-pressure
    localparam int BUDGET       = NUM_ENTRIES * (RESET_CYCLES + MAX_INSNS + 400);

    logic               clk;
    logic               rst_n;
    logic               load_en;
    logic [IMEM_AW-1:0] load_addr;
    insn_t              load_data;
    logic               io_valid;
    word_t              io_data;
    logic               io_ready;
    logic [7:0]         seg;
    logic [3:0]         an;
    logic               halt;

    // program table
    insn_t       prog [NUM_ENTRIES][MAX_INSNS];
    int          prog_len [NUM_ENTRIES];
    word_t       exp_out [NUM_ENTRIES][MAX_WORDS];
    int          exp_cnt [NUM_ENTRIES];
    logic [15:0] exp_disp [NUM_ENTRIES];
    int          hold_low [NUM_ENTRIES];

    int cur_entry;
    int out_idx;
    int hold_left;

    tenyr_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .io_valid  (io_valid),
        .io_data   (io_data),
        .io_ready  (io_ready),
        .seg       (seg),
        .an        (an),
        .halt      (halt)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_word(word_t got, word_t exp, int idx);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: output word %0d is %h, expected %h", $time, idx, got, exp);
            stop_run();
        end
    endtask

    task automatic check_digit(logic [3:0] got, logic [3:0] exp, int k);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: digit %0d shows %h, expected %h", $time, k, got, exp);
            stop_run();
        end
    endtask

    function automatic void add_insn(int e, opcode_t op, logic [3:0] rd, logic [3:0] ra,
                                     logic [3:0] rb, logic [15:0] imm);
        insn_t i;
        i.opcode = op;
        i.rd     = rd;
        i.ra     = ra;
        i.rb     = rb;
        i.imm    = imm;
        prog[e][prog_len[e]] = i;
        prog_len[e]++;
    endfunction

    function automatic void add_word(int e, word_t w);
        exp_out[e][exp_cnt[e]] = w;
        exp_cnt[e]++;
    endfunction

    // bit 4 flags a pattern that is not in the table
    function automatic logic [4:0] decode_seg(logic [7:0] s);
        for (int i = 0; i < 16; i++) begin
            if (SEG_TABLE[i] == s) begin
                return {1'b0, 4'(i)};
            end
        end
        return 5'h10;
    endfunction

    function automatic void build_table();
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            prog_len[e] = 0;
            exp_cnt[e]  = 0;
            exp_disp[e] = 16'h0000;
            hold_low[e] = 0;
        end
        // li then st to the output port
        add_insn(0, op_li, 4'd1, 4'd0, 4'd0, 16'h1234);
        add_insn(0, op_st, 4'd0, 4'd1, 4'd0, IO_ADDR);
        add_insn(0, op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
        add_word(0, 32'h0000_1234);
        // add, sub, and over 3c5a and 0ff0
        add_insn(1, op_li, 4'd1, 4'd0, 4'd0, 16'h3c5a);
        add_insn(1, op_li, 4'd2, 4'd0, 4'd0, 16'h0ff0);
        add_insn(1, op_add, 4'd3, 4'd1, 4'd2, 16'h0000);
        add_insn(1, op_st, 4'd0, 4'd3, 4'd0, IO_ADDR);
        add_insn(1, op_sub, 4'd4, 4'd1, 4'd2, 16'h0000);
        add_insn(1, op_st, 4'd0, 4'd4, 4'd0, IO_ADDR);
        add_insn(1, op_and, 4'd5, 4'd1, 4'd2, 16'h0000);
        add_insn(1, op_st, 4'd0, 4'd5, 4'd0, IO_ADDR);
        add_insn(1, op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
        add_word(1, 32'h0000_4c4a);
        add_word(1, 32'h0000_2c6a);
        add_word(1, 32'h0000_0c50);
        // or, xor, then a write to r0 that must read back as zero
        add_insn(2, op_li, 4'd1, 4'd0, 4'd0, 16'h3c5a);
        add_insn(2, op_li, 4'd2, 4'd0, 4'd0, 16'h0ff0);
        add_insn(2, op_or, 4'd6, 4'd1, 4'd2, 16'h0000);
        add_insn(2, op_st, 4'd0, 4'd6, 4'd0, IO_ADDR);
        add_insn(2, op_xor, 4'd7, 4'd1, 4'd2, 16'h0000);
        add_insn(2, op_st, 4'd0, 4'd7, 4'd0, IO_ADDR);
        add_insn(2, op_li, 4'd0, 4'd0, 4'd0, 16'h5555);
        add_insn(2, op_st, 4'd0, 4'd0, 4'd0, IO_ADDR);
        add_insn(2, op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
        add_word(2, 32'h0000_3ffa);
        add_word(2, 32'h0000_33aa);
        add_word(2, 32'h0000_0000);
        // six stores against four credits, port stalled for 50 cycles
        add_insn(3, op_li, 4'd1, 4'd0, 4'd0, 16'h0a01);
        add_insn(3, op_li, 4'd2, 4'd0, 4'd0, 16'h0b02);
        add_insn(3, op_li, 4'd3, 4'd0, 4'd0, 16'h0c03);
        add_insn(3, op_st, 4'd0, 4'd1, 4'd0, IO_ADDR);
        add_insn(3, op_st, 4'd0, 4'd2, 4'd0, IO_ADDR);
        add_insn(3, op_st, 4'd0, 4'd3, 4'd0, IO_ADDR);
        add_insn(3, op_add, 4'd4, 4'd1, 4'd3, 16'h0000);
        add_insn(3, op_st, 4'd0, 4'd4, 4'd0, IO_ADDR);
        add_insn(3, op_add, 4'd5, 4'd4, 4'd1, 16'h0000);
        add_insn(3, op_st, 4'd0, 4'd5, 4'd0, IO_ADDR);
        add_insn(3, op_st, 4'd0, 4'd0, 4'd0, IO_ADDR);
        add_insn(3, op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
        add_word(3, 32'h0000_0a01);
        add_word(3, 32'h0000_0b02);
        add_word(3, 32'h0000_0c03);
        add_word(3, 32'h0000_1604);
        add_word(3, 32'h0000_2005);
        add_word(3, 32'h0000_0000);
        hold_low[3] = 50;
        // display store, scanned after halt
        add_insn(4, op_li, 4'd1, 4'd0, 4'd0, 16'h4c7d);
        add_insn(4, op_st, 4'd0, 4'd1, 4'd0, DISPLAY_ADDR);
        add_insn(4, op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
        exp_disp[4] = 16'h4c7d;
        // unmapped store leaves the display alone
        add_insn(5, op_li, 4'd1, 4'd0, 4'd0, 16'h2468);
        add_insn(5, op_st, 4'd0, 4'd1, 4'd0, DISPLAY_ADDR);
        add_insn(5, op_li, 4'd2, 4'd0, 4'd0, 16'h1357);
        add_insn(5, op_st, 4'd0, 4'd2, 4'd0, 16'h0300);
        add_insn(5, op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
        exp_disp[5] = 16'h2468;
        // halt mid program, nothing after it may show up
        add_insn(6, op_li, 4'd1, 4'd0, 4'd0, 16'h0077);
        add_insn(6, op_st, 4'd0, 4'd1, 4'd0, IO_ADDR);
        add_insn(6, op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
        add_insn(6, op_li, 4'd2, 4'd0, 4'd0, 16'h0088);
        add_insn(6, op_st, 4'd0, 4'd2, 4'd0, IO_ADDR);
        add_insn(6, op_st, 4'd0, 4'd2, 4'd0, DISPLAY_ADDR);
        add_insn(6, op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
        add_word(6, 32'h0000_0077);
        // fresh program after the early halt
        add_insn(7, op_li, 4'd1, 4'd0, 4'd0, 16'h9abc);
        add_insn(7, op_st, 4'd0, 4'd1, 4'd0, IO_ADDR);
        add_insn(7, op_st, 4'd0, 4'd1, 4'd0, DISPLAY_ADDR);
        add_insn(7, op_nop, 4'd0, 4'd0, 4'd0, 16'h0000);
        add_insn(7, op_halt, 4'd0, 4'd0, 4'd0, 16'h0000);
        add_word(7, 32'h0000_9abc);
        exp_disp[7] = 16'h9abc;
    endfunction

    // io_ready, 30 % low, or held low right after reset when the entry asks
    initial begin
        void'($urandom(32'hf382_a19b));
        io_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (hold_left > 0) begin
                io_ready = 1'b0;
                if (rst_n) begin
                    hold_left--;
                end
            end else begin
                io_ready = ($urandom % 10) >= 3;
            end
        end
    end

    // scoreboard, one word per accepted handshake
    always @(posedge clk) begin
        if (rst_n && io_valid && io_ready) begin
            if (out_idx >= exp_cnt[cur_entry]) begin
                $display("[FAIL] %0t ns: unexpected output word %h", $time, io_data);
                stop_run();
            end else begin
                check_word(io_data, exp_out[cur_entry][out_idx], out_idx);
                out_idx++;
            end
        end
    end

    initial begin
        repeat (BUDGET) @(posedge clk);
        $display("halt never rose within %0d cycles", BUDGET);
        stop_run();
    end

    // wait for the start of digit 0, then walk all four digits
    task automatic check_scan(int e);
        logic [3:0] prev_an;
        logic [4:0] dec;
        prev_an = an;
        @(negedge clk);
        while (an != 4'b1110 || prev_an == 4'b1110) begin
            prev_an = an;
            @(negedge clk);
        end
        for (int k = 0; k < 4; k++) begin
            for (int c = 0; c < SCAN_CYCLES; c++) begin
                if (an !== ~(4'b0001 << k)) begin
                    $display("[FAIL] %0t ns: anode %b while digit %0d should be lit", $time, an, k);
                    stop_run();
                end
                dec = decode_seg(seg);
                if (dec[4]) begin
                    $display("[FAIL] %0t ns: segment pattern %h is not a hex digit",
                             $time, seg);
                    stop_run();
                end
                check_digit(dec[3:0], exp_disp[e][4*k +: 4], k);
                @(negedge clk);
            end
        end
        if (an !== 4'b1110) begin
            $display("[FAIL] %0t ns: digit 3 stayed lit past its slot", $time);
            stop_run();
        end
    endtask

    task automatic run_entry(int e);
        cur_entry = e;
        out_idx   = 0;
        hold_left = hold_low[e];
        rst_n     = 1'b0;
        // load during reset, ram keeps its contents across it
        for (int c = 0; c < RESET_CYCLES; c++) begin
            load_en   = (c < prog_len[e]);
            load_addr = IMEM_AW'(c);
            load_data = (c < prog_len[e]) ? prog[e][c] : '0;
            @(negedge clk);
        end
        load_en = 1'b0;
        rst_n   = 1'b1;
        while (halt !== 1'b1) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        if (halt !== 1'b1) begin
            $display("[FAIL] %0t ns: halt dropped before reset in entry %0d", $time, e);
            stop_run();
        end
        if (out_idx != exp_cnt[e]) begin
            $display("[FAIL] %0t ns: entry %0d delivered %0d output words, %0d expected",
                     $time, e, out_idx, exp_cnt[e]);
            stop_run();
        end
        check_scan(e);
    endtask

    initial begin
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        cur_entry = 0;
        out_idx   = 0;
        hold_left = 0;
        build_table();
        @(negedge clk);
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
tenyr_pkg.sv
insn_if.sv
store_if.sv
fetch_stage.sv
execute_stage.sv
store_stage.sv
seg7_scan.sv
tenyr_top.sv
tb_tenyr_properties.sv
tb_tenyr.sv

// File: run.sh
#!/bin/sh
# build and run the tenyr testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_tenyr -f all.f -o tb_tenyr
./obj_dir/tb_tenyr
